/* Makefile */
TOOL    := verilator
FLAGS   := --binary --timing --assert
TOP     := tb_chn_regs
FLIST   := tb.f
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* chn_ahb_slave.sv */
module chn_ahb_slave
  import chn_bus_pkg::*;
(
  input  logic        hclk,
  input  logic        hrst_n,
  input  logic        hsel,
  input  haddr_t      haddr,
  input  htrans_e     htrans,
  input  logic        hwrite,
  input  hdata_t      hwdata,
  input  hdata_t      cfg_rdata,
  input  hdata_t      int_rdata,
  output hdata_t      hrdata,
  output reg_access_t acc
);

  logic     valid;
  logic     hit;
  reg_off_t off;
  reg_sel_e sel_d;
  logic     wr_q;
  logic     rd_q;
  reg_sel_e sel_q;

  assign valid = hsel && (htrans == NONSEQ || htrans == SEQ);

  // addresses below the base wrap to large offsets and miss the map.
  assign off = reg_off_t'(haddr[9:0] - CHN_BASE);

  always_comb begin
    case (off)
      SARN_OFF:       sel_d = SEL_SARN;
      DARN_OFF:       sel_d = SEL_DARN;
      CTRL_A_OFF:     sel_d = SEL_CTRL_A;
      CTRL_B_OFF:     sel_d = SEL_CTRL_B;
      INT_MASK_OFF:   sel_d = SEL_INT_MASK;
      INT_STATUS_OFF: sel_d = SEL_INT_STATUS;
      INT_CLEAR_OFF:  sel_d = SEL_INT_CLEAR;
      SOFT_REQ_OFF:   sel_d = SEL_SOFT_REQ;
      CHN_EN_OFF:     sel_d = SEL_CHN_EN;
      default:        sel_d = SEL_NONE;
    endcase
  end

  assign hit = valid && (sel_d != SEL_NONE);

  // address phase to data phase.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      wr_q  <= 1'b0;
      rd_q  <= 1'b0;
      sel_q <= SEL_NONE;
    end else begin
      wr_q  <= hit && hwrite;
      rd_q  <= hit && !hwrite;
      sel_q <= hit ? sel_d : SEL_NONE;
    end
  end

  assign acc = '{wr: wr_q, rd: rd_q, sel: sel_q, wdata: hwdata};

  // unselected blocks return zero, so an or is enough.
  assign hrdata = rd_q ? (cfg_rdata | int_rdata) : '0;

  a_wr_rd_excl: assert property (
    @(posedge hclk) disable iff (!hrst_n)
    !(acc.wr && acc.rd)
  ) else $error("read and write in the same data phase");

endmodule

/* chn_bus_pkg.sv */
package chn_bus_pkg;

  // ahb transfer type, as driven on htrans.
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  typedef logic [31:0] haddr_t;
  typedef logic [31:0] hdata_t;
  typedef logic [9:0]  reg_off_t; // only haddr[9:0] is decoded.

  localparam reg_off_t CHN_BASE = 10'h150;

  // offsets from CHN_BASE.
  localparam reg_off_t SARN_OFF       = 10'h000;
  localparam reg_off_t DARN_OFF       = 10'h004;
  localparam reg_off_t CTRL_A_OFF     = 10'h008;
  localparam reg_off_t CTRL_B_OFF     = 10'h00C;
  localparam reg_off_t INT_MASK_OFF   = 10'h010;
  localparam reg_off_t INT_STATUS_OFF = 10'h014;
  localparam reg_off_t INT_CLEAR_OFF  = 10'h018;
  localparam reg_off_t SOFT_REQ_OFF   = 10'h01C;
  localparam reg_off_t CHN_EN_OFF     = 10'h020;

  typedef enum logic [3:0] {
    SEL_NONE       = 4'd0,
    SEL_SARN       = 4'd1,
    SEL_DARN       = 4'd2,
    SEL_CTRL_A     = 4'd3,
    SEL_CTRL_B     = 4'd4,
    SEL_INT_MASK   = 4'd5,
    SEL_INT_STATUS = 4'd6,
    SEL_INT_CLEAR  = 4'd7,
    SEL_SOFT_REQ   = 4'd8,
    SEL_CHN_EN     = 4'd9
  } reg_sel_e;

  // one register access, valid during its data phase.
  typedef struct packed {
    logic     wr;
    logic     rd;
    reg_sel_e sel;
    hdata_t   wdata; // follows hwdata of the data phase.
  } reg_access_t;

endpackage

/* chn_cfg_pkg.sv */
package chn_cfg_pkg;

  typedef logic [11:0] block_tl_t;
  typedef logic [3:0]  group_len_t;
  typedef logic [1:0]  addr_inc_t;
  typedef logic [1:0]  tr_width_t;
  typedef logic [2:0]  int_mode_t;
  typedef logic [1:0]  trg_mode_t;
  typedef logic [3:0]  prot_t;

  // channel configuration as seen by the transfer state machine.
  typedef struct packed {
    logic [31:0] sarn;
    logic [31:0] darn;
    // control word a.
    logic        dgrpaddrc;
    logic        sgrpaddrc;
    logic        grpmc;
    int_mode_t   chintmdc;
    block_tl_t   block_tl;
    group_len_t  group_len;
    addr_inc_t   sinc;
    addr_inc_t   dinc;
    tr_width_t   src_tr_width;
    tr_width_t   dst_tr_width;
    // control word b.
    prot_t       protctl;
    logic        endlan;
    logic        srcdtlgc;
    trg_mode_t   trgtmdc;
    logic        int_en;
  } chn_cfg_t;

  // interrupt sources, bit 3 down to bit 0 on the bus.
  typedef struct packed {
    logic trgetcmp;
    logic htfr;
    logic tfr;
    logic err;
  } int_src_t;

endpackage

/* chn_cfg_regs.sv */
module chn_cfg_regs
  import chn_bus_pkg::*;
  import chn_cfg_pkg::*;
(
  input  logic        hclk,
  input  logic        hrst_n,
  input  reg_access_t acc,
  input  logic        chnen_clr,
  output chn_cfg_t    cfg,
  output logic        chn_en,
  output logic        sfwtrg,
  output hdata_t      rdata
);

  chn_cfg_t cfg_q;
  logic     cfg_wr;
  logic     en_wr;
  logic     soft_req;
  hdata_t   ctrl_a_rd;
  hdata_t   ctrl_b_rd;

  assign cfg_wr = acc.wr && !chn_en; // configuration locked while enabled.
  assign en_wr  = acc.wr && (acc.sel == SEL_CHN_EN);

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      cfg_q <= '0;
    end else if (cfg_wr) begin
      case (acc.sel)
        SEL_SARN: cfg_q.sarn <= acc.wdata;
        SEL_DARN: cfg_q.darn <= acc.wdata;
        SEL_CTRL_A: begin
          cfg_q.dgrpaddrc    <= acc.wdata[31];
          cfg_q.sgrpaddrc    <= acc.wdata[29];
          cfg_q.grpmc        <= acc.wdata[28];
          cfg_q.chintmdc     <= acc.wdata[26:24];
          cfg_q.block_tl     <= acc.wdata[23:12];
          cfg_q.group_len    <= acc.wdata[11:8];
          cfg_q.sinc         <= acc.wdata[7:6];
          cfg_q.dinc         <= acc.wdata[5:4];
          cfg_q.src_tr_width <= acc.wdata[3:2];
          cfg_q.dst_tr_width <= acc.wdata[1:0];
        end
        SEL_CTRL_B: begin
          cfg_q.protctl  <= acc.wdata[18:15];
          cfg_q.endlan   <= acc.wdata[14];
          cfg_q.srcdtlgc <= acc.wdata[13];
          cfg_q.trgtmdc  <= acc.wdata[2:1];
          cfg_q.int_en   <= acc.wdata[0];
        end
        default: ;
      endcase
    end
  end

  // a bus write wins over the clear from the state machine.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      chn_en <= 1'b0;
    end else if (en_wr) begin
      chn_en <= acc.wdata[0];
    end else if (chnen_clr) begin
      chn_en <= 1'b0;
    end
  end

  // request is held one cycle, then leaves as the sfwtrg pulse.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      soft_req <= 1'b0;
      sfwtrg   <= 1'b0;
    end else begin
      soft_req <= acc.wr && (acc.sel == SEL_SOFT_REQ) && acc.wdata[0];
      sfwtrg   <= soft_req;
    end
  end

  assign cfg = cfg_q;

  assign ctrl_a_rd = {cfg_q.dgrpaddrc, 1'b0, cfg_q.sgrpaddrc, cfg_q.grpmc, 1'b0,
                      cfg_q.chintmdc, cfg_q.block_tl, cfg_q.group_len,
                      cfg_q.sinc, cfg_q.dinc, cfg_q.src_tr_width, cfg_q.dst_tr_width};

  assign ctrl_b_rd = {13'h0, cfg_q.protctl, cfg_q.endlan, cfg_q.srcdtlgc,
                      10'h0, cfg_q.trgtmdc, cfg_q.int_en};

  always_comb begin
    case (acc.sel)
      SEL_SARN:   rdata = cfg_q.sarn;
      SEL_DARN:   rdata = cfg_q.darn;
      SEL_CTRL_A: rdata = ctrl_a_rd;
      SEL_CTRL_B: rdata = ctrl_b_rd;
      SEL_CHN_EN: rdata = {31'h0, chn_en};
      default:    rdata = '0;
    endcase
  end

  // only the rising edge of chn_en may still see a configuration write.
  a_cfg_lock: assert property (
    @(posedge hclk) disable iff (!hrst_n)
    chn_en |=> $stable(cfg_q)
  ) else $error("configuration changed while channel enabled");

endmodule

/* chn_int_ctrl.sv */
module chn_int_ctrl
  import chn_bus_pkg::*;
  import chn_cfg_pkg::*;
(
  input  logic        hclk,
  input  logic        hrst_n,
  input  reg_access_t acc,
  input  int_src_t    int_evt,
  input  logic        int_en,
  output logic        irq,
  output hdata_t      rdata
);

  int_src_t mask_q;
  int_src_t status_q;
  int_src_t clr_q;

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      mask_q <= '0;
    end else if (acc.wr && (acc.sel == SEL_INT_MASK)) begin
      mask_q <= int_src_t'(acc.wdata[3:0]);
    end
  end

  // write one to clear gives a single cycle pulse.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      clr_q <= '0;
    end else if (acc.wr && (acc.sel == SEL_INT_CLEAR)) begin
      clr_q <= int_src_t'(acc.wdata[3:0]);
    end else begin
      clr_q <= '0;
    end
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      status_q <= '0;
    end else begin
      status_q <= int_src_t'(int_evt | (status_q & ~clr_q)); // set beats clear.
    end
  end

  assign irq = int_en && (|(status_q & mask_q));

  always_comb begin
    case (acc.sel)
      SEL_INT_MASK:   rdata = {28'h0, mask_q};
      SEL_INT_STATUS: rdata = {28'h0, status_q};
      default:        rdata = '0;
    endcase
  end

  a_irq_gated: assert property (
    @(posedge hclk) disable iff (!hrst_n)
    irq |-> int_en
  ) else $error("irq raised with interrupts disabled");

endmodule

/* chn_regs_top.sv */
module chn_regs_top
  import chn_bus_pkg::*;
  import chn_cfg_pkg::*;
(
  input  logic     hclk,
  input  logic     hrst_n,
  input  logic     hsel,
  input  haddr_t   haddr,
  input  htrans_e  htrans,
  input  logic     hwrite,
  input  hdata_t   hwdata,
  input  logic     chnen_clr,
  input  int_src_t int_evt,
  output chn_cfg_t cfg,
  output logic     chn_en,
  output logic     sfwtrg,
  output logic     irq,
  output hdata_t   hrdata
);

  reg_access_t acc;
  hdata_t      cfg_rdata;
  hdata_t      int_rdata;

  chn_ahb_slave slave_i (
    .hclk      (hclk),
    .hrst_n    (hrst_n),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .hwdata    (hwdata),
    .cfg_rdata (cfg_rdata),
    .int_rdata (int_rdata),
    .hrdata    (hrdata),
    .acc       (acc)
  );

  chn_cfg_regs cfg_i (
    .hclk      (hclk),
    .hrst_n    (hrst_n),
    .acc       (acc),
    .chnen_clr (chnen_clr),
    .cfg       (cfg),
    .chn_en    (chn_en),
    .sfwtrg    (sfwtrg),
    .rdata     (cfg_rdata)
  );

  chn_int_ctrl int_i (
    .hclk    (hclk),
    .hrst_n  (hrst_n),
    .acc     (acc),
    .int_evt (int_evt),
    .int_en  (cfg.int_en), // channel interrupt enable from control word b.
    .irq     (irq),
    .rdata   (int_rdata)
  );

endmodule

/* tb.f */
chn_bus_pkg.sv
chn_cfg_pkg.sv
chn_ahb_slave.sv
chn_cfg_regs.sv
chn_int_ctrl.sv
chn_regs_top.sv
tb_chn_regs.sv

/* tb_chn_regs.sv */
module tb_chn_regs
  import chn_bus_pkg::*;
  import chn_cfg_pkg::*;
();

  localparam int CLK_PERIOD    = 100;
  localparam int DRV_DLY       = 10;
  localparam int PULSE_TIMEOUT = 8;
  localparam hdata_t CTRL_A_MASK = 32'hB7FF_FFFF;
  localparam hdata_t CTRL_B_MASK = 32'h0007_E007;

  logic     hclk;
  logic     hrst_n;
  logic     hsel;
  haddr_t   haddr;
  htrans_e  htrans;
  logic     hwrite;
  hdata_t   hwdata;
  logic     chnen_clr;
  int_src_t int_evt;
  chn_cfg_t cfg;
  logic     chn_en;
  logic     sfwtrg;
  logic     irq;
  hdata_t   hrdata;

  integer seed = 32'h59e6;
  int     errors = 0;
  int     checks = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     errs_at_start = 0;

  chn_regs_top dut_i (
    .hclk(hclk), .hrst_n(hrst_n), .hsel(hsel), .haddr(haddr), .htrans(htrans),
    .hwrite(hwrite), .hwdata(hwdata), .chnen_clr(chnen_clr), .int_evt(int_evt),
    .cfg(cfg), .chn_en(chn_en), .sfwtrg(sfwtrg), .irq(irq), .hrdata(hrdata)
  );

  initial begin
    hclk = 1'b0;
    forever #(CLK_PERIOD / 2) hclk = ~hclk;
  end

  task automatic next_cycle();
    @(posedge hclk);
    #DRV_DLY;
  endtask

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH time=%0t signal=%s expected=0x%08h actual=0x%08h",
               $time, name, exp, act);
    end
  endtask

  function automatic haddr_t reg_addr(input reg_off_t off);
    reg_addr = {22'h10_0000, reg_off_t'(CHN_BASE + off)}; // upper bits are not decoded.
  endfunction

  // address phase followed by a data phase with an idle address phase.
  task automatic ahb_access(input logic sel, input htrans_e trans, input logic write,
                            input haddr_t addr, input hdata_t wdata, output hdata_t rdata);
    hsel   = sel;
    htrans = trans;
    hwrite = write;
    haddr  = addr;
    next_cycle();
    hsel   = 1'b0;
    htrans = IDLE;
    hwrite = 1'b0;
    haddr  = '0;
    hwdata = wdata;
    rdata  = hrdata; // mid data phase.
    next_cycle();
  endtask

  task automatic ahb_write(input reg_off_t off, input hdata_t data);
    hdata_t unused_rd;
    ahb_access(1'b1, NONSEQ, 1'b1, reg_addr(off), data, unused_rd);
  endtask

  task automatic ahb_read(input reg_off_t off, output hdata_t data);
    ahb_access(1'b1, NONSEQ, 1'b0, reg_addr(off), '0, data);
  endtask

  task automatic pulse_event(input int_src_t evt);
    int_evt = evt;
    next_cycle();
    int_evt = '0;
  endtask

  function automatic logic irq_model(input logic en, input int_src_t st, input int_src_t mk);
    irq_model = en && (|(st & mk));
  endfunction

  task automatic report_test(input string name);
    tests_run++;
    if (errors != errs_at_start) begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - errs_at_start);
    end else begin
      $display("%s: ok", name);
    end
    errs_at_start = errors;
  endtask

  task automatic check_reset_values();
    reg_off_t offs[9];
    hdata_t   rd;
    offs = '{SARN_OFF, DARN_OFF, CTRL_A_OFF, CTRL_B_OFF, INT_MASK_OFF,
             INT_STATUS_OFF, INT_CLEAR_OFF, SOFT_REQ_OFF, CHN_EN_OFF};
    expect_eq("irq", 32'h0, 32'(irq));
    expect_eq("sfwtrg", 32'h0, 32'(sfwtrg));
    expect_eq("chn_en", 32'h0, 32'(chn_en));
    for (int i = 0; i < 9; i++) begin
      ahb_read(offs[i], rd);
      expect_eq($sformatf("hrdata at offset 0x%03h", offs[i]), 32'h0, rd);
    end
    report_test("reset values");
  endtask

  task automatic config_round_trip();
    hdata_t ws;
    hdata_t wd;
    hdata_t wa;
    hdata_t wb;
    hdata_t rd;
    repeat (3) begin
      ws = $random(seed);
      wd = $random(seed);
      wa = $random(seed);
      wb = $random(seed);
      ahb_write(SARN_OFF, ws);
      ahb_write(DARN_OFF, wd);
      ahb_write(CTRL_A_OFF, wa);
      ahb_write(CTRL_B_OFF, wb);
      ahb_read(SARN_OFF, rd);
      expect_eq("hrdata sarn", ws, rd);
      ahb_read(DARN_OFF, rd);
      expect_eq("hrdata darn", wd, rd);
      ahb_read(CTRL_A_OFF, rd);
      expect_eq("hrdata ctrl_a", wa & CTRL_A_MASK, rd);
      ahb_read(CTRL_B_OFF, rd);
      expect_eq("hrdata ctrl_b", wb & CTRL_B_MASK, rd);
      expect_eq("cfg.sarn", ws, cfg.sarn);
      expect_eq("cfg.darn", wd, cfg.darn);
      expect_eq("cfg.dgrpaddrc", 32'(wa[31]), 32'(cfg.dgrpaddrc));
      expect_eq("cfg.sgrpaddrc", 32'(wa[29]), 32'(cfg.sgrpaddrc));
      expect_eq("cfg.grpmc", 32'(wa[28]), 32'(cfg.grpmc));
      expect_eq("cfg.chintmdc", 32'(wa[26:24]), 32'(cfg.chintmdc));
      expect_eq("cfg.block_tl", 32'(wa[23:12]), 32'(cfg.block_tl));
      expect_eq("cfg.group_len", 32'(wa[11:8]), 32'(cfg.group_len));
      expect_eq("cfg.sinc", 32'(wa[7:6]), 32'(cfg.sinc));
      expect_eq("cfg.dinc", 32'(wa[5:4]), 32'(cfg.dinc));
      expect_eq("cfg.src_tr_width", 32'(wa[3:2]), 32'(cfg.src_tr_width));
      expect_eq("cfg.dst_tr_width", 32'(wa[1:0]), 32'(cfg.dst_tr_width));
      expect_eq("cfg.protctl", 32'(wb[18:15]), 32'(cfg.protctl));
      expect_eq("cfg.endlan", 32'(wb[14]), 32'(cfg.endlan));
      expect_eq("cfg.srcdtlgc", 32'(wb[13]), 32'(cfg.srcdtlgc));
      expect_eq("cfg.trgtmdc", 32'(wb[2:1]), 32'(cfg.trgtmdc));
      expect_eq("cfg.int_en", 32'(wb[0]), 32'(cfg.int_en));
    end
    report_test("configuration round trip");
  endtask

  task automatic enable_lock();
    hdata_t rd;
    ahb_write(SARN_OFF, 32'h0000_1000);
    ahb_write(DARN_OFF, 32'h0000_2000);
    ahb_write(CTRL_A_OFF, 32'h0000_4321);
    ahb_write(CTRL_B_OFF, 32'h0000_0000);
    ahb_write(CHN_EN_OFF, 32'h1);
    expect_eq("chn_en", 32'h1, 32'(chn_en));
    ahb_read(CHN_EN_OFF, rd);
    expect_eq("hrdata chn_en", 32'h1, rd);
    ahb_write(SARN_OFF, 32'hFFFF_0000); // dropped while enabled.
    ahb_write(DARN_OFF, 32'hFFFF_1111);
    ahb_write(CTRL_A_OFF, 32'h8765_4321);
    ahb_write(CTRL_B_OFF, 32'h0007_E007);
    ahb_read(SARN_OFF, rd);
    expect_eq("hrdata sarn", 32'h0000_1000, rd);
    ahb_read(DARN_OFF, rd);
    expect_eq("hrdata darn", 32'h0000_2000, rd);
    ahb_read(CTRL_A_OFF, rd);
    expect_eq("hrdata ctrl_a", 32'h0000_4321, rd);
    ahb_read(CTRL_B_OFF, rd);
    expect_eq("hrdata ctrl_b", 32'h0, rd);
    expect_eq("cfg.sarn", 32'h0000_1000, cfg.sarn);
    expect_eq("cfg.int_en", 32'h0, 32'(cfg.int_en));
    ahb_write(INT_MASK_OFF, 32'hA);
    ahb_read(INT_MASK_OFF, rd);
    expect_eq("hrdata int_mask", 32'hA, rd);
    chnen_clr = 1'b1;
    next_cycle();
    chnen_clr = 1'b0;
    expect_eq("chn_en", 32'h0, 32'(chn_en));
    ahb_write(SARN_OFF, 32'hFFFF_0000);
    ahb_read(SARN_OFF, rd);
    expect_eq("hrdata sarn", 32'hFFFF_0000, rd);
    ahb_write(INT_MASK_OFF, 32'h0);
    report_test("enable lock");
  endtask

  task automatic interrupt_paths();
    int_src_t st;
    int_src_t mk;
    logic     en;
    hdata_t   rd;
    en = 1'b1;
    mk = '0;
    st = '0;
    ahb_write(CTRL_B_OFF, 32'h1);
    ahb_write(INT_MASK_OFF, 32'h0);
    pulse_event(int_src_t'(4'b0101));
    st = int_src_t'(st | 4'b0101);
    ahb_read(INT_STATUS_OFF, rd);
    expect_eq("hrdata int_status", 32'(st), rd);
    expect_eq("irq", 32'(irq_model(en, st, mk)), 32'(irq));
    mk = int_src_t'(4'b0100);
    ahb_write(INT_MASK_OFF, 32'(mk));
    expect_eq("irq", 32'(irq_model(en, st, mk)), 32'(irq));
    mk = int_src_t'(4'b1010);
    ahb_write(INT_MASK_OFF, 32'(mk));
    expect_eq("irq", 32'(irq_model(en, st, mk)), 32'(irq));
    pulse_event(int_src_t'(4'b1010));
    st = int_src_t'(st | 4'b1010);
    expect_eq("irq", 32'(irq_model(en, st, mk)), 32'(irq));
    en = 1'b0;
    ahb_write(CTRL_B_OFF, 32'h0);
    expect_eq("irq", 32'(irq_model(en, st, mk)), 32'(irq));
    en = 1'b1;
    ahb_write(CTRL_B_OFF, 32'h1);
    ahb_write(INT_CLEAR_OFF, 32'b1001); // only trgetcmp and err.
    st = int_src_t'(st & 4'b0110);
    ahb_read(INT_STATUS_OFF, rd);
    expect_eq("hrdata int_status", 32'(st), rd);
    expect_eq("irq", 32'(irq_model(en, st, mk)), 32'(irq));
    ahb_write(INT_CLEAR_OFF, 32'hF);
    ahb_read(INT_STATUS_OFF, rd);
    expect_eq("hrdata int_status", 32'h0, rd);
    ahb_write(INT_MASK_OFF, 32'h0);
    ahb_write(CTRL_B_OFF, 32'h0);
    report_test("interrupts");
  endtask

  task automatic software_request();
    int waited;
    int pulses;
    ahb_write(SOFT_REQ_OFF, 32'h1);
    waited = 0;
    while (!sfwtrg && waited < PULSE_TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (!sfwtrg) begin
      errors++;
      $display("ERROR time=%0t sfwtrg did not pulse within %0d cycles of the write",
               $time, PULSE_TIMEOUT);
    end else begin
      expect_eq("sfwtrg cycles after write", 32'h1, 32'(waited));
    end
    next_cycle();
    expect_eq("sfwtrg", 32'h0, 32'(sfwtrg)); // one cycle wide.
    ahb_write(SOFT_REQ_OFF, 32'hFFFF_FFFE);
    pulses = 0;
    repeat (6) begin
      if (sfwtrg) pulses++;
      next_cycle();
    end
    expect_eq("sfwtrg pulses", 32'h0, 32'(pulses));
    report_test("software request");
  endtask

  task automatic ignored_transfers();
    hdata_t rd;
    ahb_write(SARN_OFF, 32'h1234_5678);
    ahb_write(INT_MASK_OFF, 32'h5);
    ahb_access(1'b1, IDLE, 1'b1, reg_addr(SARN_OFF), 32'hDEAD_BEEF, rd);
    ahb_access(1'b1, BUSY, 1'b1, reg_addr(SARN_OFF), 32'hDEAD_BEEF, rd);
    ahb_access(1'b0, NONSEQ, 1'b1, reg_addr(SARN_OFF), 32'hDEAD_BEEF, rd);
    ahb_access(1'b0, SEQ, 1'b1, reg_addr(CHN_EN_OFF), 32'h1, rd);
    ahb_access(1'b1, NONSEQ, 1'b1, reg_addr(10'h024), 32'hFFFF_FFFF, rd);
    ahb_access(1'b1, NONSEQ, 1'b1, {22'h0, 10'h14C}, 32'hFFFF_FFFF, rd); // below base.
    ahb_access(1'b1, IDLE, 1'b0, reg_addr(SARN_OFF), '0, rd);
    expect_eq("hrdata idle read", 32'h0, rd);
    ahb_read(SARN_OFF, rd);
    expect_eq("hrdata sarn", 32'h1234_5678, rd);
    ahb_read(INT_MASK_OFF, rd);
    expect_eq("hrdata int_mask", 32'h5, rd);
    expect_eq("chn_en", 32'h0, 32'(chn_en));
    ahb_read(10'h024, rd);
    expect_eq("hrdata offset 0x024", 32'h0, rd);
    ahb_access(1'b1, NONSEQ, 1'b0, {22'h0, 10'h14C}, '0, rd);
    expect_eq("hrdata below base", 32'h0, rd);
    ahb_read(INT_CLEAR_OFF, rd);
    expect_eq("hrdata int_clear", 32'h0, rd);
    report_test("ignored transfers");
  endtask

  initial begin
    #(CLK_PERIOD * 2000);
    $display("ERROR simulation did not finish in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    hrst_n    = 1'b0;
    hsel      = 1'b0;
    haddr     = '0;
    htrans    = IDLE;
    hwrite    = 1'b0;
    hwdata    = '0;
    chnen_clr = 1'b0;
    int_evt   = '0;
    repeat (8) @(posedge hclk);
    #DRV_DLY;
    hrst_n = 1'b1;
    next_cycle();
    check_reset_values();
    config_round_trip();
    enable_lock();
    interrupt_paths();
    software_request();
    ignored_transfers();
    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
